/* hw/scalar_config.svh */
/*
 * Scalar core configuration
 * Data width, register count, instruction memory depth and the
 * Wishbone word address map of the host port
 */
`ifndef SCALAR_CONFIG_SVH
`define SCALAR_CONFIG_SVH

// Datapath
`define SCALAR_DATA_WIDTH       32
`define SCALAR_REG_COUNT        16
`define SCALAR_IMEM_DEPTH       64

// Host bus, word addresses
`define SCALAR_WB_ADDR_WIDTH    10
`define SCALAR_WB_BASE_IMEM     10'h000
`define SCALAR_WB_BASE_CTRL     10'h100
`define SCALAR_WB_BASE_REGS     10'h200

`endif

/* hw/scalar_isa_pkg.sv */
/*
 * Scalar ISA package
 * Register values, register numbers, instruction addresses,
 * opcodes and the 32-bit instruction word layout
 */
`include "scalar_config.svh"

package scalar_isa_pkg;

	typedef logic [`SCALAR_DATA_WIDTH-1:0]          data_t;
	typedef logic [$clog2(`SCALAR_REG_COUNT)-1:0]   reg_idx_t;
	typedef logic [$clog2(`SCALAR_IMEM_DEPTH)-1:0]  pc_t;
	typedef logic [15:0]                            imm_t;

	typedef enum logic [3:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		OR   = 4'h4,
		XOR  = 4'h5,
		ADDI = 4'h6,
		SLT  = 4'h7,
		BNE  = 4'h8,
		JMP  = 4'h9,
		HALT = 4'hA
	} opcode_e;

	// Opcode in the top nibble, immediate in the low half
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t     imm;
	} instr_t;

	// Ops that produce a register result
	function automatic logic op_writes(opcode_e op);
		case (op)
			ADD, SUB, AND, OR, XOR, ADDI, SLT: return 1'b1;
			default:                           return 1'b0;
		endcase
	endfunction

endpackage

/* hw/scalar_uarch_pkg.sv */
/*
 * Scalar micro-architecture package
 * Host bus request and response, run control states and the
 * records passed between the pipeline stages
 */
`include "scalar_config.svh"

package scalar_uarch_pkg;

	import scalar_isa_pkg::*;

	typedef logic [`SCALAR_WB_ADDR_WIDTH-1:0] wb_addr_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		data_t    dat_w;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		data_t dat_r;
	} wb_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		RUNNING,
		DONE
	} run_state_e;

	////////////////////////////////
	// Pipeline records

	typedef struct packed {
		logic   valid;
		pc_t    pc;
		instr_t instr;
	} fetch_t;

	// Source bank bits pick even or odd bank data in execute
	typedef struct packed {
		logic     valid;
		opcode_e  op;
		reg_idx_t dst;
		logic     src1_bank;
		logic     src2_bank;
		imm_t     imm;
		pc_t      pc;
	} issue_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t idx;
		data_t    data;
	} rf_write_t;

	typedef struct packed {
		logic valid;
		logic halt;
		pc_t  target;
	} redirect_t;

	typedef struct packed {
		reg_idx_t reg_idx;
		pc_t      mem_addr;
	} host_rd_t;

endpackage

/* hw/wb_host_port.sv */
/*
 * Wishbone host port
 * Classic slave with a single-cycle ack, address decode into
 * instruction memory, control word and register file, and the
 * run/done control state machine
 */
`timescale 1ns/100ps
`include "scalar_config.svh"

module wb_host_port (
	input  logic                        clock,
	input  logic                        reset,
	input  scalar_uarch_pkg::wb_req_t   wb_req,
	output scalar_uarch_pkg::wb_rsp_t   wb_rsp,
	input  logic                        halt_seen,
	input  scalar_isa_pkg::data_t       imem_rdata,
	input  scalar_isa_pkg::data_t       reg_rdata_even,
	input  scalar_isa_pkg::data_t       reg_rdata_odd,
	output logic                        imem_we,
	output scalar_isa_pkg::pc_t         imem_waddr,
	output scalar_isa_pkg::data_t       imem_wdata,
	output scalar_uarch_pkg::host_rd_t  host_rd,
	output logic                        start,
	output logic                        running,
	output logic                        halted
);
	import scalar_isa_pkg::*;
	import scalar_uarch_pkg::*;

	localparam int       ADDR_W    = $bits(wb_addr_t);
	localparam int       PC_W      = $bits(pc_t);
	localparam int       REG_W     = $bits(reg_idx_t);
	localparam wb_addr_t BASE_IMEM = `SCALAR_WB_BASE_IMEM;
	localparam wb_addr_t BASE_CTRL = `SCALAR_WB_BASE_CTRL;
	localparam wb_addr_t BASE_REGS = `SCALAR_WB_BASE_REGS;

	run_state_e state_q;
	run_state_e state_next;
	logic       fire;
	logic       is_imem;
	logic       is_ctrl;
	logic       is_regs;
	logic       start_wr;
	logic       ack_q;
	logic       rd_mem_q;
	logic       rd_reg_q;
	logic       rd_ctrl_q;
	logic       rd_odd_q;

	// New access seen, not yet acknowledged
	assign fire    = wb_req.cyc & wb_req.stb & ~ack_q;
	assign is_imem = wb_req.adr[ADDR_W-1:PC_W] == BASE_IMEM[ADDR_W-1:PC_W];
	assign is_regs = wb_req.adr[ADDR_W-1:REG_W] == BASE_REGS[ADDR_W-1:REG_W];
	assign is_ctrl = wb_req.adr == BASE_CTRL;

	assign running = state_q == RUNNING;
	assign halted  = state_q == DONE;

	// Memory writes only land while the core is stopped
	assign imem_we    = fire & wb_req.we & is_imem & ~running;
	assign imem_waddr = wb_req.adr[PC_W-1:0];
	assign imem_wdata = wb_req.dat_w;

	assign host_rd.reg_idx  = wb_req.adr[REG_W-1:0];
	assign host_rd.mem_addr = wb_req.adr[PC_W-1:0];

	////////////////////////////////
	// Run control

	assign start_wr = fire & wb_req.we & is_ctrl & wb_req.dat_w[0];
	assign start    = start_wr & ~running;

	always_comb begin
		state_next = state_q;
		case (state_q)
			IDLE, DONE: begin
				if (start_wr) begin
					state_next = RUNNING;
				end
			end
			RUNNING: begin
				if (halt_seen) begin
					state_next = DONE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_next;
		end
	end

	////////////////////////////////
	// Response

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q     <= 1'b0;
			rd_mem_q  <= 1'b0;
			rd_reg_q  <= 1'b0;
			rd_ctrl_q <= 1'b0;
		end else begin
			ack_q     <= fire;
			rd_mem_q  <= fire & ~wb_req.we & is_imem & ~running;
			rd_reg_q  <= fire & ~wb_req.we & is_regs & ~running;
			rd_ctrl_q <= fire & ~wb_req.we & is_ctrl;
		end
		rd_odd_q <= wb_req.adr[0];
	end

	// Memory and bank reads are registered, so data lines up with ack
	always_comb begin
		wb_rsp.ack   = ack_q;
		wb_rsp.dat_r = '0;
		if (rd_mem_q) begin
			wb_rsp.dat_r = imem_rdata;
		end else if (rd_reg_q) begin
			wb_rsp.dat_r = rd_odd_q ? reg_rdata_odd : reg_rdata_even;
		end else if (rd_ctrl_q) begin
			wb_rsp.dat_r = data_t'({halted, running});
		end
	end

endmodule

/* hw/instr_mem.sv */
/*
 * Instruction memory
 * Single-clock word memory with a host write/read port and a
 * fetch read port, both reads registered
 */
`timescale 1ns/100ps
`include "scalar_config.svh"

module instr_mem (
	input  logic                   clock,
	input  logic                   we,
	input  scalar_isa_pkg::pc_t    waddr,
	input  scalar_isa_pkg::data_t  wdata,
	input  scalar_isa_pkg::pc_t    host_addr,
	output scalar_isa_pkg::data_t  host_rdata,
	input  scalar_isa_pkg::pc_t    fetch_addr,
	output scalar_isa_pkg::instr_t fetch_instr
);
	import scalar_isa_pkg::*;

	data_t mem [`SCALAR_IMEM_DEPTH];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		host_rdata  <= mem[host_addr];
		fetch_instr <= instr_t'(mem[fetch_addr]);
	end

endmodule

/* hw/fetch_unit.sv */
/*
 * Fetch stage
 * Program counter with start, redirect and stall handling. The
 * memory is addressed with the next PC, so its output register
 * always holds the word at the current PC
 */
`timescale 1ns/100ps

module fetch_unit (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          start,
	input  logic                          running,
	input  logic                          stall,
	input  scalar_uarch_pkg::redirect_t   redirect,
	output scalar_isa_pkg::pc_t           imem_addr,
	input  scalar_isa_pkg::instr_t        imem_instr,
	output scalar_uarch_pkg::fetch_t      fetched
);
	import scalar_isa_pkg::*;

	pc_t  pc_q;
	pc_t  pc_next;
	logic valid_q;

	// Redirect wins over a stall, start wins over both
	always_comb begin
		pc_next = pc_q;
		if (start) begin
			pc_next = '0;
		end else if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (running && valid_q && !stall) begin
			pc_next = pc_q + 1'b1;
		end
	end

	assign imem_addr = pc_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q    <= '0;
			valid_q <= 1'b0;
		end else begin
			pc_q <= pc_next;
			if (start) begin
				valid_q <= 1'b1;
			end else if (redirect.valid) begin
				// Target word is valid next cycle unless halting
				valid_q <= ~redirect.halt;
			end else begin
				valid_q <= valid_q & running;
			end
		end
	end

	assign fetched.valid = valid_q;
	assign fetched.pc    = pc_q;
	assign fetched.instr = imem_instr;

endmodule

/* hw/issue_hazard.sv */
/*
 * Issue stage
 * Decodes the fetched word, checks RAW and WAW hazards against a
 * pending-write scoreboard and issues into execute. A hazard
 * stalls fetch so the word is held there
 */
`timescale 1ns/100ps
`include "scalar_config.svh"

module issue_hazard (
	input  logic                          clock,
	input  logic                          reset,
	input  scalar_uarch_pkg::fetch_t      fetched,
	input  scalar_uarch_pkg::redirect_t   redirect,
	input  scalar_uarch_pkg::rf_write_t   rf_write,
	output logic                          stall,
	output scalar_uarch_pkg::issue_t      issued,
	output scalar_isa_pkg::reg_idx_t      rd_idx1,
	output scalar_isa_pkg::reg_idx_t      rd_idx2
);
	import scalar_isa_pkg::*;

	instr_t                        instr;
	logic                          use_src1;
	logic                          use_src2;
	logic                          writes;
	logic                          hazard;
	logic                          do_issue;
	logic [`SCALAR_REG_COUNT-1:0]  pending;

	assign instr = fetched.instr;

	always_comb begin
		use_src1 = 1'b0;
		use_src2 = 1'b0;
		case (instr.opcode)
			ADD, SUB, AND, OR, XOR, SLT, BNE: begin
				use_src1 = 1'b1;
				use_src2 = 1'b1;
			end
			ADDI: use_src1 = 1'b1;
			default: ;
		endcase
	end

	assign writes = op_writes(instr.opcode);

	////////////////////////////////
	// Hazard check

	// RAW on either source, WAW on the destination
	assign hazard = (use_src1 & pending[instr.src1])
		| (use_src2 & pending[instr.src2])
		| (writes & pending[instr.dst]);

	assign stall = fetched.valid & hazard;

	// Wrong-path word is dropped while execute redirects
	assign do_issue = fetched.valid & ~hazard & ~redirect.valid;

	// Banks register these, data meets the issued op in execute
	assign rd_idx1 = instr.src1;
	assign rd_idx2 = instr.src2;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (rf_write.valid) begin
				pending[rf_write.idx] <= 1'b0;
			end
			if (do_issue && writes) begin
				pending[instr.dst] <= 1'b1;
			end
		end
	end

	////////////////////////////////
	// Issue register

	always_ff @(posedge clock) begin
		if (reset) begin
			issued.valid <= 1'b0;
		end else begin
			issued.valid <= do_issue;
		end
		issued.op        <= instr.opcode;
		issued.dst       <= instr.dst;
		issued.src1_bank <= instr.src1[0];
		issued.src2_bank <= instr.src2[0];
		issued.imm       <= instr.imm;
		issued.pc        <= fetched.pc;
	end

endmodule

/* hw/reg_bank.sv */
/*
 * Register bank
 * Half of the register file, selected by the low index bit.
 * Two issue read ports, one host read port and one write port,
 * all reads registered
 */
`timescale 1ns/100ps
`include "scalar_config.svh"

module reg_bank #(
	parameter bit BANK_PARITY = 1'b0
) (
	input  logic                          clock,
	input  logic                          reset,
	input  scalar_uarch_pkg::rf_write_t   rf_write,
	input  scalar_isa_pkg::reg_idx_t      rd_idx1,
	input  scalar_isa_pkg::reg_idx_t      rd_idx2,
	input  scalar_isa_pkg::reg_idx_t      host_idx,
	output scalar_isa_pkg::data_t         rd_data1,
	output scalar_isa_pkg::data_t         rd_data2,
	output scalar_isa_pkg::data_t         host_data
);
	import scalar_isa_pkg::*;

	localparam int REG_W = $bits(reg_idx_t);
	localparam int DEPTH = `SCALAR_REG_COUNT / 2;

	data_t regs [DEPTH];
	logic  bank_we;

	// Upper index bits address the slot within this bank
	assign bank_we = rf_write.valid & (rf_write.idx[0] == BANK_PARITY);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (bank_we) begin
			regs[rf_write.idx[REG_W-1:1]] <= rf_write.data;
		end
	end

	always_ff @(posedge clock) begin
		rd_data1  <= regs[rd_idx1[REG_W-1:1]];
		rd_data2  <= regs[rd_idx2[REG_W-1:1]];
		host_data <= regs[host_idx[REG_W-1:1]];
	end

endmodule

/* hw/exec_unit.sv */
/*
 * Execute stage
 * Picks operands from the even or odd bank, runs the ALU,
 * resolves BNE, JMP and HALT into a redirect and registers
 * the write-back
 */
`timescale 1ns/100ps

module exec_unit (
	input  logic                          clock,
	input  logic                          reset,
	input  scalar_uarch_pkg::issue_t      issued,
	input  scalar_isa_pkg::data_t         even_data1,
	input  scalar_isa_pkg::data_t         even_data2,
	input  scalar_isa_pkg::data_t         odd_data1,
	input  scalar_isa_pkg::data_t         odd_data2,
	output scalar_uarch_pkg::redirect_t   redirect,
	output scalar_uarch_pkg::rf_write_t   rf_write
);
	import scalar_isa_pkg::*;

	data_t src_a;
	data_t src_b;
	data_t imm_ext;
	data_t result;
	logic  taken;
	logic  is_halt;

	assign src_a   = issued.src1_bank ? odd_data1 : even_data1;
	assign src_b   = issued.src2_bank ? odd_data2 : even_data2;
	assign imm_ext = data_t'(signed'(issued.imm));

	always_comb begin
		case (issued.op)
			ADD:     result = src_a + src_b;
			SUB:     result = src_a - src_b;
			AND:     result = src_a & src_b;
			OR:      result = src_a | src_b;
			XOR:     result = src_a ^ src_b;
			ADDI:    result = src_a + imm_ext;
			SLT:     result = data_t'($signed(src_a) < $signed(src_b));
			default: result = '0;
		endcase
	end

	////////////////////////////////
	// Control flow

	assign taken   = (issued.op == JMP) | ((issued.op == BNE) & (src_a != src_b));
	assign is_halt = issued.valid & (issued.op == HALT);

	// Halt parks fetch on its own address
	always_comb begin
		redirect.valid  = issued.valid & (taken | is_halt);
		redirect.halt   = is_halt;
		redirect.target = is_halt ? issued.pc : pc_t'(issued.imm);
	end

	// Bank write lands in the following cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			rf_write.valid <= 1'b0;
		end else begin
			rf_write.valid <= issued.valid & op_writes(issued.op);
		end
		rf_write.idx  <= issued.dst;
		rf_write.data <= result;
	end

endmodule

/* hw/scalar_core_top.sv */
/*
 * Scalar core top level
 * Host port, instruction memory, fetch, issue and execute
 * stages and the even and odd register banks
 */
`timescale 1ns/100ps

module scalar_core_top (
	input  logic                        clock,
	input  logic                        reset,
	input  scalar_uarch_pkg::wb_req_t   wb_req,
	output scalar_uarch_pkg::wb_rsp_t   wb_rsp,
	output logic                        halted
);
	import scalar_isa_pkg::*;
	import scalar_uarch_pkg::*;

	logic      imem_we;
	pc_t       imem_waddr;
	data_t     imem_wdata;
	data_t     imem_host_rdata;
	host_rd_t  host_rd;
	logic      start;
	logic      running;
	pc_t       imem_addr;
	instr_t    imem_instr;
	fetch_t    fetched;
	logic      stall;
	redirect_t redirect;
	issue_t    issued;
	reg_idx_t  rd_idx1;
	reg_idx_t  rd_idx2;
	rf_write_t rf_write;
	data_t     even_data1;
	data_t     even_data2;
	data_t     odd_data1;
	data_t     odd_data2;
	data_t     even_host;
	data_t     odd_host;

	////////////////////////////////
	// Host side

	wb_host_port host_i (
		.clock          (clock),
		.reset          (reset),
		.wb_req         (wb_req),
		.wb_rsp         (wb_rsp),
		.halt_seen      (redirect.halt),
		.imem_rdata     (imem_host_rdata),
		.reg_rdata_even (even_host),
		.reg_rdata_odd  (odd_host),
		.imem_we        (imem_we),
		.imem_waddr     (imem_waddr),
		.imem_wdata     (imem_wdata),
		.host_rd        (host_rd),
		.start          (start),
		.running        (running),
		.halted         (halted)
	);

	instr_mem imem_i (
		.clock       (clock),
		.we          (imem_we),
		.waddr       (imem_waddr),
		.wdata       (imem_wdata),
		.host_addr   (host_rd.mem_addr),
		.host_rdata  (imem_host_rdata),
		.fetch_addr  (imem_addr),
		.fetch_instr (imem_instr)
	);

	////////////////////////////////
	// Pipeline

	fetch_unit fetch_i (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.running    (running),
		.stall      (stall),
		.redirect   (redirect),
		.imem_addr  (imem_addr),
		.imem_instr (imem_instr),
		.fetched    (fetched)
	);

	issue_hazard issue_i (
		.clock    (clock),
		.reset    (reset),
		.fetched  (fetched),
		.redirect (redirect),
		.rf_write (rf_write),
		.stall    (stall),
		.issued   (issued),
		.rd_idx1  (rd_idx1),
		.rd_idx2  (rd_idx2)
	);

	exec_unit exec_i (
		.clock      (clock),
		.reset      (reset),
		.issued     (issued),
		.even_data1 (even_data1),
		.even_data2 (even_data2),
		.odd_data1  (odd_data1),
		.odd_data2  (odd_data2),
		.redirect   (redirect),
		.rf_write   (rf_write)
	);

	// Even registers in one bank, odd in the other
	reg_bank #(.BANK_PARITY(1'b0)) bank_even_i (
		.clock     (clock),
		.reset     (reset),
		.rf_write  (rf_write),
		.rd_idx1   (rd_idx1),
		.rd_idx2   (rd_idx2),
		.host_idx  (host_rd.reg_idx),
		.rd_data1  (even_data1),
		.rd_data2  (even_data2),
		.host_data (even_host)
	);

	reg_bank #(.BANK_PARITY(1'b1)) bank_odd_i (
		.clock     (clock),
		.reset     (reset),
		.rf_write  (rf_write),
		.rd_idx1   (rd_idx1),
		.rd_idx2   (rd_idx2),
		.host_idx  (host_rd.reg_idx),
		.rd_data1  (odd_data1),
		.rd_data2  (odd_data2),
		.host_data (odd_host)
	);

endmodule

/* verif/scalar_core_assertions.sv */
/*
 * Scalar core bound checks
 * Wishbone ack protocol on the host port and entry into the
 * done state straight from a run
 */
`timescale 1ns/100ps

module scalar_core_assertions (
	input logic                      clock,
	input logic                      reset,
	input scalar_uarch_pkg::wb_req_t wb_req,
	input scalar_uarch_pkg::wb_rsp_t wb_rsp,
	input logic                      running,
	input logic                      halted
);
	logic fail_seen;

	initial begin
		fail_seen = 1'b0;
	end

	// Ack answers a request seen one cycle earlier
	ack_follows_req: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
	) else begin
		$error("ack without a preceding cyc and stb");
		fail_seen = 1'b1;
	end

	ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack
	) else begin
		$error("ack held for more than one cycle");
		fail_seen = 1'b1;
	end

	// Done is only entered as a run ends
	halt_not_running: assert property (@(posedge clock) disable iff (reset)
		$rose(halted) |-> $fell(running)
	) else begin
		$error("halted rose without running falling");
		fail_seen = 1'b1;
	end

endmodule

bind scalar_core_top scalar_core_assertions assertions_i (
	.clock   (clock),
	.reset   (reset),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp),
	.running (running),
	.halted  (halted)
);

/* verif/scalar_core_tb.sv */
/*
 * Scalar core testbench
 * Loads random programs over the Wishbone host port, runs the
 * core to HALT and compares every register with an
 * instruction-level model of the program
 */
`timescale 1ns/100ps
`include "scalar_config.svh"

module scalar_core_tb;
	import scalar_isa_pkg::*;
	import scalar_uarch_pkg::*;

	localparam int SEED         = 6818;
	localparam int CLOCK_PERIOD = 40;
	localparam int ALU_PROGS    = 6;
	localparam int CHAIN_PROGS  = 4;
	localparam int FLOW_PROGS   = 6;
	// The last program is started twice
	localparam int RUNS         = ALU_PROGS + CHAIN_PROGS + FLOW_PROGS + 2;
	localparam int WATCHDOG_CYCLES = RUNS * 64 * 8 + 4000;

	localparam wb_addr_t IMEM_BASE = `SCALAR_WB_BASE_IMEM;
	localparam wb_addr_t CTRL_ADDR = `SCALAR_WB_BASE_CTRL;
	localparam wb_addr_t REGS_BASE = `SCALAR_WB_BASE_REGS;

	logic    clock;
	logic    reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic    halted;

	data_t prog [`SCALAR_IMEM_DEPTH];
	data_t model_regs [`SCALAR_REG_COUNT];

	scalar_core_top dut_i (
		.clock  (clock),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.halted (halted)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	//////////////////////////////
	// Failure handling

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "Run stopped at %0t ns", $time);
	endtask

	task automatic value_error(input string what, input data_t got, input data_t exp);
		$display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
		abort_run();
	endtask

	task automatic check_value(input string what, input data_t got, input data_t exp);
		assert (got == exp) else value_error(what, got, exp);
	endtask

	//////////////////////////////
	// Wishbone host

	task automatic drive_bus(input logic active, input logic we, input wb_addr_t adr,
			input data_t dat);
		wb_req.cyc   <= active;
		wb_req.stb   <= active;
		wb_req.we    <= we;
		wb_req.adr   <= adr;
		wb_req.dat_w <= dat;
	endtask

	// Ack is sampled mid-cycle, away from the clock edge
	task automatic wait_ack();
		int waited;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!wb_rsp.ack && waited < 16);
		assert (wb_rsp.ack) else begin
			$display("No Wishbone ack within 16 cycles at %0t ns", $time);
			abort_run();
		end
	endtask

	task automatic wb_write(input wb_addr_t adr, input data_t dat);
		@(posedge clock);
		drive_bus(1'b1, 1'b1, adr, dat);
		wait_ack();
		@(posedge clock);
		drive_bus(1'b0, 1'b0, '0, '0);
	endtask

	task automatic wb_read(input wb_addr_t adr, output data_t dat);
		@(posedge clock);
		drive_bus(1'b1, 1'b0, adr, '0);
		wait_ack();
		dat = wb_rsp.dat_r;
		@(posedge clock);
		drive_bus(1'b0, 1'b0, '0, '0);
	endtask

	//////////////////////////////
	// Programs and model

	function automatic data_t encode(input opcode_e op, input int dst, input int s1,
			input int s2, input int imm);
		instr_t w;
		w.opcode = op;
		w.dst    = reg_idx_t'(dst);
		w.src1   = reg_idx_t'(s1);
		w.src2   = reg_idx_t'(s2);
		w.imm    = imm_t'(imm);
		return data_t'(w);
	endfunction

	function automatic opcode_e pick_alu_op();
		case ($urandom_range(6, 0))
			0: return ADD;
			1: return SUB;
			2: return AND;
			3: return OR;
			4: return XOR;
			5: return ADDI;
			default: return SLT;
		endcase
	endfunction

	// Kind 0 plain ALU, 1 dependency chain, 2 with forward BNE and JMP
	function automatic void make_program(input int kind, input int len);
		int      prev;
		int      dst;
		int      s1;
		int      s2;
		int      target;
		opcode_e op;
		prev = $urandom_range(15, 0);
		for (int i = 0; i < len - 1; i++) begin
			op  = pick_alu_op();
			dst = $urandom_range(15, 0);
			s1  = $urandom_range(15, 0);
			s2  = $urandom_range(15, 0);
			if (kind == 1) begin
				s1 = prev;
				if ($urandom_range(1, 0) == 1) begin
					s2 = prev;
				end
			end
			if (kind == 2 && $urandom_range(3, 0) == 0) begin
				// Upper immediate bits lie outside the address range
				target = $urandom_range(len - 1, i + 1) + 64 * $urandom_range(1023, 0);
				if ($urandom_range(2, 0) == 0) begin
					op = JMP;
				end else begin
					op = BNE;
					if ($urandom_range(1, 0) == 0) begin
						s2 = s1;
					end
				end
				prog[i] = encode(op, dst, s1, s2, target);
			end else begin
				prog[i] = encode(op, dst, s1, s2, $urandom_range(65535, 0));
			end
			prev = dst;
		end
		prog[len-1] = encode(HALT, 0, 0, 0, 0);
	endfunction

	// Interpreter over the persistent model registers
	task automatic run_model();
		instr_t w;
		int     pc;
		int     steps;
		data_t  a;
		data_t  b;
		logic   stop;
		pc    = 0;
		steps = 0;
		stop  = 1'b0;
		while (!stop && steps < 1000) begin
			w  = instr_t'(prog[pc]);
			a  = model_regs[w.src1];
			b  = model_regs[w.src2];
			pc = (pc + 1) % 64;
			case (w.opcode)
				ADD:  model_regs[w.dst] = a + b;
				SUB:  model_regs[w.dst] = a - b;
				AND:  model_regs[w.dst] = a & b;
				OR:   model_regs[w.dst] = a | b;
				XOR:  model_regs[w.dst] = a ^ b;
				ADDI: model_regs[w.dst] = a + {{16{w.imm[15]}}, w.imm};
				SLT:  model_regs[w.dst] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				BNE: begin
					if (a != b) begin
						pc = int'(w.imm) % 64;
					end
				end
				JMP:  pc = int'(w.imm) % 64;
				HALT: stop = 1'b1;
				default: ;
			endcase
			steps++;
		end
	endtask

	//////////////////////////////
	// Run control

	task automatic load_program(input int len);
		for (int i = 0; i < len; i++) begin
			wb_write(IMEM_BASE + wb_addr_t'(i), prog[i]);
		end
	endtask

	task automatic wait_done();
		data_t status;
		int    polls;
		polls = 0;
		do begin
			wb_read(CTRL_ADDR, status);
			polls++;
		end while (status[1] == 1'b0 && polls < 400);
		assert (status[1]) else begin
			$display("Core never reported done after %0d status polls", polls);
			abort_run();
		end
		check_value("status after HALT", status, 32'd2);
		assert (halted) else begin
			$display("Output halted is low although status shows done");
			abort_run();
		end
	endtask

	task automatic check_regs(input string label);
		data_t got;
		for (int r = 0; r < `SCALAR_REG_COUNT; r++) begin
			wb_read(REGS_BASE + wb_addr_t'(r), got);
			check_value($sformatf("%s r%0d", label, r), got, model_regs[r]);
		end
	endtask

	task automatic run_program(input int kind, input string label);
		int len;
		len = $urandom_range(60, 8);
		make_program(kind, len);
		load_program(len);
		wb_write(CTRL_ADDR, 32'd1);
		wait_done();
		run_model();
		check_regs(label);
	endtask

	// Bound bus and run-control checks end the run here
	always @(negedge clock) begin
		assert (!dut_i.assertions_i.fail_seen) else begin
			$display("A bound bus or run-control assertion failed at %0t ns", $time);
			abort_run();
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Watchdog timeout, the run did not finish in time");
		abort_run();
	end

	initial begin
		data_t got;
		data_t exp;
		void'($urandom(SEED));
		clock  = 1'b0;
		reset  = 1'b1;
		wb_req = '0;
		for (int r = 0; r < `SCALAR_REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		wb_read(CTRL_ADDR, got);
		check_value("status after reset", got, '0);
		assert (!halted) else begin
			$display("Output halted is high after reset");
			abort_run();
		end
		check_regs("reset");

		// Memory write and read back while idle
		for (int i = 0; i < `SCALAR_IMEM_DEPTH; i++) begin
			prog[i] = $urandom();
			wb_write(IMEM_BASE + wb_addr_t'(i), prog[i]);
		end
		for (int i = 0; i < `SCALAR_IMEM_DEPTH; i++) begin
			wb_read(IMEM_BASE + wb_addr_t'(i), got);
			check_value($sformatf("imem word %0d", i), got, prog[i]);
		end

		for (int p = 0; p < ALU_PROGS; p++) begin
			run_program(0, "alu");
		end
		for (int p = 0; p < CHAIN_PROGS; p++) begin
			run_program(1, "chain");
		end
		for (int p = 0; p < FLOW_PROGS; p++) begin
			run_program(2, "flow");
		end

		// Long chain keeps the core busy during host accesses
		make_program(1, 60);
		load_program(60);
		exp = prog[5];
		wb_write(CTRL_ADDR, 32'd1);
		wb_read(CTRL_ADDR, got);
		check_value("status while running", got, 32'd1);
		assert (!halted) else begin
			$display("Output halted is high while the core runs");
			abort_run();
		end
		wb_read(REGS_BASE + 10'd3, got);
		check_value("register read while running", got, '0);
		wb_read(IMEM_BASE + 10'd5, got);
		check_value("imem read while running", got, '0);
		wb_write(IMEM_BASE + 10'd5, ~exp);
		wait_done();
		run_model();
		check_regs("busy run");
		wb_read(IMEM_BASE + 10'd5, got);
		check_value("imem word after ignored write", got, exp);

		// Restart from address 0 on the same program
		wb_write(CTRL_ADDR, 32'd1);
		wait_done();
		run_model();
		check_regs("restart");

		$display("All tests passed");
		$finish;
	end

endmodule

/* list.f */
+incdir+hw
hw/scalar_isa_pkg.sv
hw/scalar_uarch_pkg.sv
hw/wb_host_port.sv
hw/instr_mem.sv
hw/fetch_unit.sv
hw/issue_hazard.sv
hw/reg_bank.sv
hw/exec_unit.sv
hw/scalar_core_top.sv
verif/scalar_core_assertions.sv
verif/scalar_core_tb.sv

/* Makefile */
TOP := scalar_core_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(wildcard hw/*.sv hw/*.svh verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^All tests passed$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
